/* spike_pkg.sv */
`default_nettype none

package spike_pkg;

  // Bundle geometry
  localparam int LANES    = 5;
  localparam int CHANNELS = 64;

  // Output FIFO depth in words
  localparam int FIFO_DEPTH = 16;

  // Band-passed sample, two's complement
  typedef logic signed [15:0] sample_t;

  // Channel number as delivered with each sample
  typedef logic [11:0] chan_t;

  // Threshold bank index, low bits of the channel number
  typedef logic [5:0] thr_addr_t;

  // Bank entry: threshold in [31:16], offset in [15:0]
  typedef logic [31:0] thr_word_t;

  typedef logic [2:0] lane_idx_t;

  // Output word: {spike, lane, channel, corrected sample}
  typedef logic [31:0] out_word_t;

  // Host register port
  typedef logic [4:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // Occupancy 0..FIFO_DEPTH
  typedef logic [4:0] fifo_level_t;

  // Serializer FSM
  typedef enum logic [0:0] {
    IDLE,
    EMIT
  } ser_state_t;

  // Register map
  localparam reg_addr_t REG_CTRL   = 5'd0;
  localparam reg_addr_t REG_STATUS = 5'd1;

endpackage

`default_nettype wire

/* ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
  input  wire                    bus_clk,
  input  wire                    arst_n,
  input  wire                    reg_wren,
  input  spike_pkg::reg_addr_t   reg_addr,
  input  spike_pkg::reg_data_t   reg_wdata,
  output spike_pkg::reg_data_t   reg_rdata,
  input  wire                    fifo_drop,
  input  spike_pkg::fifo_level_t fifo_level,
  output logic                   detect_en
);

  logic overflow;
  logic ctrl_wr;
  logic status_wr;

  assign ctrl_wr   = reg_wren && (reg_addr == spike_pkg::REG_CTRL);
  assign status_wr = reg_wren && (reg_addr == spike_pkg::REG_STATUS);

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      detect_en <= 1'b0;
    end else if (ctrl_wr) begin
      detect_en <= reg_wdata[0];
    end
  end

  // Sticky overflow, a new drop wins over a clear in the same cycle
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      overflow <= 1'b0;
    end else if (fifo_drop) begin
      overflow <= 1'b1;
    end else if (status_wr && reg_wdata[0]) begin
      overflow <= 1'b0;
    end
  end

  // Readback
  always_comb begin
    reg_rdata = '0;
    case (reg_addr)
      spike_pkg::REG_CTRL: begin
        reg_rdata[0] = detect_en;
      end
      spike_pkg::REG_STATUS: begin
        reg_rdata[0]    = overflow;
        reg_rdata[12:8] = fifo_level;
      end
      default: reg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* thresh_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module thresh_bank (
  input  wire                                        bus_clk,
  input  wire                                        arst_n,
  input  wire                                        thr_wren,
  input  spike_pkg::thr_addr_t                       thr_addr,
  input  spike_pkg::thr_word_t                       thr_wdata,
  output spike_pkg::thr_word_t                       thr_rdata,
  input  spike_pkg::chan_t   [spike_pkg::LANES-1:0]  lookup_chans,
  output spike_pkg::thr_word_t [spike_pkg::LANES-1:0] lookup_words
);

  // One threshold/offset pair per channel
  spike_pkg::thr_word_t bank [spike_pkg::CHANNELS];

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < spike_pkg::CHANNELS; i++) begin
        bank[i] <= '0;
      end
    end else if (thr_wren) begin
      bank[thr_addr] <= thr_wdata;
    end
  end

  // Host readback follows the address
  assign thr_rdata = bank[thr_addr];

  // Lane lookups, channel number folded onto the bank size
  always_comb begin
    for (int i = 0; i < spike_pkg::LANES; i++) begin
      lookup_words[i] = bank[spike_pkg::thr_addr_t'(lookup_chans[i])];
    end
  end

endmodule

`default_nettype wire

/* spike_detect.sv */
`timescale 1ns/1ps
`default_nettype none

module spike_detect (
  input  wire                                          bus_clk,
  input  wire                                          arst_n,
  input  wire                                          detect_en,
  input  wire                                          in_valid,
  input  spike_pkg::sample_t   [spike_pkg::LANES-1:0]  in_samples,
  input  spike_pkg::chan_t     [spike_pkg::LANES-1:0]  in_chans,
  output spike_pkg::chan_t     [spike_pkg::LANES-1:0]  lookup_chans,
  input  spike_pkg::thr_word_t [spike_pkg::LANES-1:0]  lookup_words,
  output logic                                         det_valid,
  output spike_pkg::sample_t   [spike_pkg::LANES-1:0]  det_samples,
  output spike_pkg::chan_t     [spike_pkg::LANES-1:0]  det_chans,
  output logic                 [spike_pkg::LANES-1:0]  det_spikes
);

  // Stage 1 registers
  logic                                        s1_valid;
  spike_pkg::sample_t   [spike_pkg::LANES-1:0] s1_samples;
  spike_pkg::chan_t     [spike_pkg::LANES-1:0] s1_chans;
  spike_pkg::thr_word_t [spike_pkg::LANES-1:0] s1_words;

  // Stage 2 inputs
  spike_pkg::sample_t [spike_pkg::LANES-1:0] corrected;
  logic               [spike_pkg::LANES-1:0] below;

  // Bank is addressed straight from the incoming bundle
  assign lookup_chans = in_chans;

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (in_valid) begin
      s1_samples <= in_samples;
      s1_chans   <= in_chans;
      s1_words   <= lookup_words;
    end
  end

  // Offset removal wraps at 16 bits, compare is signed
  always_comb begin
    for (int i = 0; i < spike_pkg::LANES; i++) begin
      corrected[i] = s1_samples[i] - spike_pkg::sample_t'(s1_words[i][15:0]);
      below[i]     = corrected[i] < spike_pkg::sample_t'(s1_words[i][31:16]);
    end
  end

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      det_valid <= 1'b0;
    end else begin
      det_valid <= s1_valid;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (s1_valid) begin
      det_samples <= corrected;
      det_chans   <= s1_chans;
      det_spikes  <= detect_en ? below : '0;
    end
  end

endmodule

`default_nettype wire

/* lane_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_serializer (
  input  wire                                        bus_clk,
  input  wire                                        arst_n,
  input  wire                                        det_valid,
  input  spike_pkg::sample_t [spike_pkg::LANES-1:0]  det_samples,
  input  spike_pkg::chan_t   [spike_pkg::LANES-1:0]  det_chans,
  input  wire                [spike_pkg::LANES-1:0]  det_spikes,
  output logic                                       wr_en,
  output spike_pkg::out_word_t                       wr_word
);

  spike_pkg::ser_state_t state;
  spike_pkg::lane_idx_t  lane;
  logic                  last_lane;
  logic                  load;

  // Latched bundle
  spike_pkg::sample_t [spike_pkg::LANES-1:0] samples_q;
  spike_pkg::chan_t   [spike_pkg::LANES-1:0] chans_q;
  logic               [spike_pkg::LANES-1:0] spikes_q;

  assign last_lane = (lane == spike_pkg::lane_idx_t'(spike_pkg::LANES - 1));

  // Back-to-back bundles are taken on the last lane
  assign load = det_valid && (state == spike_pkg::IDLE || last_lane);

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= spike_pkg::IDLE;
      lane  <= '0;
    end else if (load) begin
      state <= spike_pkg::EMIT;
      lane  <= '0;
    end else if (state == spike_pkg::EMIT) begin
      if (last_lane) begin
        state <= spike_pkg::IDLE;
      end
      lane <= lane + 1'b1;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (load) begin
      samples_q <= det_samples;
      chans_q   <= det_chans;
      spikes_q  <= det_spikes;
    end
  end

  // One word per cycle while emitting
  assign wr_en   = (state == spike_pkg::EMIT);
  assign wr_word = {spikes_q[lane], lane, chans_q[lane], samples_q[lane]};

  // Bundles arrive no closer than one per LANES cycles
  a_spacing: assert property (
    @(posedge bus_clk) disable iff (!arst_n)
      (det_valid && state == spike_pkg::EMIT) |-> last_lane
  ) else $error("lane_serializer: bundle arrived while lanes still pending");

endmodule

`default_nettype wire

/* host_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module host_fifo (
  input  wire                    bus_clk,
  input  wire                    arst_n,
  input  wire                    wr_en,
  input  spike_pkg::out_word_t   wr_word,
  input  wire                    rd_en,
  output spike_pkg::out_word_t   fifo_data,
  output logic                   fifo_empty,
  output spike_pkg::fifo_level_t fifo_level,
  output logic                   fifo_drop
);

  spike_pkg::out_word_t mem [spike_pkg::FIFO_DEPTH];

  logic [$clog2(spike_pkg::FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(spike_pkg::FIFO_DEPTH)-1:0] rd_ptr;
  logic full;
  logic push;
  logic pop;

  assign full       = (fifo_level == spike_pkg::fifo_level_t'(spike_pkg::FIFO_DEPTH));
  assign fifo_empty = (fifo_level == '0);

  // A pop frees a slot for a write in the same cycle
  assign pop       = rd_en && !fifo_empty;
  assign push      = wr_en && (!full || pop);
  assign fifo_drop = wr_en && !push;

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_level <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fifo_level <= fifo_level + push - pop;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  // Head word is shown without a read request
  assign fifo_data = mem[rd_ptr];

  a_level: assert property (
    @(posedge bus_clk) disable iff (!arst_n)
      fifo_level <= spike_pkg::fifo_level_t'(spike_pkg::FIFO_DEPTH)
  ) else $error("host_fifo: level above depth");

  a_rd_empty: assert property (
    @(posedge bus_clk) disable iff (!arst_n) rd_en |-> !fifo_empty
  ) else $error("host_fifo: read while empty");

endmodule

`default_nettype wire

/* spike_pipeline_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spike_pipeline_top (
  input  wire                                        bus_clk,
  input  wire                                        arst_n,
  input  wire                                        in_valid,
  input  spike_pkg::sample_t [spike_pkg::LANES-1:0]  in_samples,
  input  spike_pkg::chan_t   [spike_pkg::LANES-1:0]  in_chans,
  input  wire                                        thr_wren,
  input  spike_pkg::thr_addr_t                       thr_addr,
  input  spike_pkg::thr_word_t                       thr_wdata,
  output spike_pkg::thr_word_t                       thr_rdata,
  input  wire                                        reg_wren,
  input  spike_pkg::reg_addr_t                       reg_addr,
  input  spike_pkg::reg_data_t                       reg_wdata,
  output spike_pkg::reg_data_t                       reg_rdata,
  input  wire                                        rd_en,
  output spike_pkg::out_word_t                       fifo_data,
  output logic                                       fifo_empty
);

  logic                                        detect_en;
  logic                                        fifo_drop;
  spike_pkg::fifo_level_t                      fifo_level;
  spike_pkg::chan_t     [spike_pkg::LANES-1:0] lookup_chans;
  spike_pkg::thr_word_t [spike_pkg::LANES-1:0] lookup_words;

  // Detector to serializer
  logic                                        det_valid;
  spike_pkg::sample_t   [spike_pkg::LANES-1:0] det_samples;
  spike_pkg::chan_t     [spike_pkg::LANES-1:0] det_chans;
  logic                 [spike_pkg::LANES-1:0] det_spikes;

  // Serializer to FIFO
  logic                                        wr_en;
  spike_pkg::out_word_t                        wr_word;

  ctrl_regs u_ctrl_regs (
    .bus_clk    (bus_clk   ),
    .arst_n     (arst_n    ),
    .reg_wren   (reg_wren  ),
    .reg_addr   (reg_addr  ),
    .reg_wdata  (reg_wdata ),
    .reg_rdata  (reg_rdata ),
    .fifo_drop  (fifo_drop ),
    .fifo_level (fifo_level),
    .detect_en  (detect_en )
  );

  thresh_bank u_thresh_bank (
    .bus_clk      (bus_clk     ),
    .arst_n       (arst_n      ),
    .thr_wren     (thr_wren    ),
    .thr_addr     (thr_addr    ),
    .thr_wdata    (thr_wdata   ),
    .thr_rdata    (thr_rdata   ),
    .lookup_chans (lookup_chans),
    .lookup_words (lookup_words)
  );

  spike_detect u_spike_detect (
    .bus_clk      (bus_clk     ),
    .arst_n       (arst_n      ),
    .detect_en    (detect_en   ),
    .in_valid     (in_valid    ),
    .in_samples   (in_samples  ),
    .in_chans     (in_chans    ),
    .lookup_chans (lookup_chans),
    .lookup_words (lookup_words),
    .det_valid    (det_valid   ),
    .det_samples  (det_samples ),
    .det_chans    (det_chans   ),
    .det_spikes   (det_spikes  )
  );

  lane_serializer u_lane_serializer (
    .bus_clk     (bus_clk    ),
    .arst_n      (arst_n     ),
    .det_valid   (det_valid  ),
    .det_samples (det_samples),
    .det_chans   (det_chans  ),
    .det_spikes  (det_spikes ),
    .wr_en       (wr_en      ),
    .wr_word     (wr_word    )
  );

  host_fifo u_host_fifo (
    .bus_clk    (bus_clk   ),
    .arst_n     (arst_n    ),
    .wr_en      (wr_en     ),
    .wr_word    (wr_word   ),
    .rd_en      (rd_en     ),
    .fifo_data  (fifo_data ),
    .fifo_empty (fifo_empty),
    .fifo_level (fifo_level),
    .fifo_drop  (fifo_drop )
  );

endmodule

`default_nettype wire

/* tb_spike_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spike_pipeline;

  localparam int CLK_PERIOD       = 40;
  localparam int RESET_CYCLES     = 8;
  localparam int DRIVE_DLY        = 1;
  localparam int SAMPLE_DLY       = 10;
  localparam int BUNDLE_GAP       = 8;
  localparam int RANDOM_BUNDLES   = 40;
  localparam int EDGE_BUNDLES     = 1;
  localparam int OVERFLOW_BUNDLES = 6;
  localparam int TOTAL_BUNDLES    = 2 * RANDOM_BUNDLES + EDGE_BUNDLES + OVERFLOW_BUNDLES;
  localparam int TIMEOUT_CYCLES   = 2 * TOTAL_BUNDLES * 8 + 2000;

  logic                                        bus_clk = 1'b0;
  logic                                        arst_n;
  logic                                        in_valid;
  spike_pkg::sample_t   [spike_pkg::LANES-1:0] in_samples;
  spike_pkg::chan_t     [spike_pkg::LANES-1:0] in_chans;
  logic                                        thr_wren;
  spike_pkg::thr_addr_t                        thr_addr;
  spike_pkg::thr_word_t                        thr_wdata;
  spike_pkg::thr_word_t                        thr_rdata;
  logic                                        reg_wren;
  spike_pkg::reg_addr_t                        reg_addr;
  spike_pkg::reg_data_t                        reg_wdata;
  spike_pkg::reg_data_t                        reg_rdata;
  logic                                        rd_en = 1'b0;
  spike_pkg::out_word_t                        fifo_data;
  logic                                        fifo_empty;

  // Host view of the bank and the words still owed by the DUT
  spike_pkg::thr_word_t shadow [spike_pkg::CHANNELS];
  spike_pkg::out_word_t exp_q [$];
  logic                 draining = 1'b0;
  logic [31:0]          lfsr_state = 32'h4ec1778b;
  int                   cycle_count = 0;
  int                   spikes_seen = 0;
  int                   quiet_seen = 0;

  spike_pipeline_top UUT (
    .bus_clk    (bus_clk   ),
    .arst_n     (arst_n    ),
    .in_valid   (in_valid  ),
    .in_samples (in_samples),
    .in_chans   (in_chans  ),
    .thr_wren   (thr_wren  ),
    .thr_addr   (thr_addr  ),
    .thr_wdata  (thr_wdata ),
    .thr_rdata  (thr_rdata ),
    .reg_wren   (reg_wren  ),
    .reg_addr   (reg_addr  ),
    .reg_wdata  (reg_wdata ),
    .reg_rdata  (reg_rdata ),
    .rd_en      (rd_en     ),
    .fifo_data  (fifo_data ),
    .fifo_empty (fifo_empty)
  );

  always #(CLK_PERIOD / 2) bus_clk = ~bus_clk;

  always @(posedge bus_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run exceeded %0d clock cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopping on first error");
  endtask

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h8020_0003;
    end
    return next;
  endfunction

  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // Reference model of one lane word
  function automatic spike_pkg::out_word_t expected_word(
    input spike_pkg::thr_word_t entry,
    input spike_pkg::sample_t   sample,
    input spike_pkg::chan_t     chan,
    input spike_pkg::lane_idx_t lane,
    input logic                 enable
  );
    logic signed [15:0] threshold;
    logic signed [15:0] offset;
    logic signed [15:0] corrected;
    logic               flag;
    threshold = entry[31:16];
    offset    = entry[15:0];
    corrected = sample - offset;
    flag      = enable && (corrected < threshold);
    return {flag, lane, chan, corrected};
  endfunction

  function automatic spike_pkg::reg_data_t status_value(input int level, input logic overflow);
    spike_pkg::reg_data_t value;
    value       = '0;
    value[0]    = overflow;
    value[12:8] = level[4:0];
    return value;
  endfunction

  task automatic check_word(input string name, input spike_pkg::out_word_t got,
                            input spike_pkg::out_word_t exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s = %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_thr(input string name, input spike_pkg::thr_word_t got,
                           input spike_pkg::thr_word_t exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s = %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_reg(input string name, input spike_pkg::reg_data_t got,
                           input spike_pkg::reg_data_t exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s = %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic write_thr(input spike_pkg::thr_addr_t addr, input spike_pkg::thr_word_t data);
    @(posedge bus_clk);
    #DRIVE_DLY;
    thr_wren     = 1'b1;
    thr_addr     = addr;
    thr_wdata    = data;
    shadow[addr] = data;
    @(posedge bus_clk);
    #DRIVE_DLY;
    thr_wren = 1'b0;
  endtask

  task automatic read_thr_check(input spike_pkg::thr_addr_t addr);
    @(posedge bus_clk);
    #DRIVE_DLY;
    thr_addr = addr;
    #SAMPLE_DLY;
    check_thr("thr_rdata", thr_rdata, shadow[addr]);
  endtask

  task automatic write_reg(input spike_pkg::reg_addr_t addr, input spike_pkg::reg_data_t data);
    @(posedge bus_clk);
    #DRIVE_DLY;
    reg_wren  = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge bus_clk);
    #DRIVE_DLY;
    reg_wren = 1'b0;
  endtask

  task automatic read_reg_check(input spike_pkg::reg_addr_t addr,
                                input spike_pkg::reg_data_t exp);
    @(posedge bus_clk);
    #DRIVE_DLY;
    reg_addr = addr;
    #SAMPLE_DLY;
    check_reg("reg_rdata", reg_rdata, exp);
  endtask

  // One strobe, then idle up to the bundle spacing
  task automatic drive_bundle(input spike_pkg::sample_t [spike_pkg::LANES-1:0] samples,
                              input spike_pkg::chan_t   [spike_pkg::LANES-1:0] chans);
    @(posedge bus_clk);
    #DRIVE_DLY;
    in_valid   = 1'b1;
    in_samples = samples;
    in_chans   = chans;
    @(posedge bus_clk);
    #DRIVE_DLY;
    in_valid = 1'b0;
    repeat (BUNDLE_GAP - 2) @(posedge bus_clk);
  endtask

  task automatic send_random_bundle(input logic enable);
    spike_pkg::sample_t   [spike_pkg::LANES-1:0] samples;
    spike_pkg::chan_t     [spike_pkg::LANES-1:0] chans;
    spike_pkg::out_word_t                        word;
    for (int i = 0; i < spike_pkg::LANES; i++) begin
      samples[i] = spike_pkg::sample_t'(take_bits(16));
      chans[i]   = spike_pkg::chan_t'(take_bits(12));
      word = expected_word(shadow[spike_pkg::thr_addr_t'(chans[i])], samples[i], chans[i],
                           spike_pkg::lane_idx_t'(i), enable);
      exp_q.push_back(word);
      if (word[31]) begin
        spikes_seen++;
      end else begin
        quiet_seen++;
      end
    end
    drive_bundle(samples, chans);
  endtask

  // Equal-to-threshold lanes and offsets that wrap
  task automatic edge_case_test();
    spike_pkg::sample_t [spike_pkg::LANES-1:0] samples;
    spike_pkg::chan_t   [spike_pkg::LANES-1:0] chans;
    write_thr(6'd0, 32'h0100_0020);
    write_thr(6'd1, 32'h0100_0020);
    write_thr(6'd2, 32'h0000_8000);
    write_thr(6'd3, 32'h0000_0010);
    write_thr(6'd4, 32'hFF00_FFFF);
    samples[0] = 16'h0120;
    samples[1] = 16'h011F;
    samples[2] = 16'h7FF0;
    samples[3] = 16'h8005;
    samples[4] = 16'hFEFF;
    for (int i = 0; i < spike_pkg::LANES; i++) begin
      chans[i] = spike_pkg::chan_t'(12'hA40 + i);
    end
    exp_q.push_back(32'h0A40_0100);
    exp_q.push_back(32'h9A41_00FF);
    exp_q.push_back(32'hAA42_FFF0);
    exp_q.push_back(32'h3A43_7FF5);
    exp_q.push_back(32'h4A44_FF00);
    drive_bundle(samples, chans);
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0 || !fifo_empty) begin
      @(negedge bus_clk);
    end
  endtask

  // Pops the head word whenever draining, one per cycle
  always @(posedge bus_clk) begin
    #DRIVE_DLY;
    if (draining && !fifo_empty) begin
      if (exp_q.size() == 0) begin
        $display("Word %h appeared in the FIFO when no word was expected", fifo_data);
        abort_run();
      end else begin
        check_word("fifo_data", fifo_data, exp_q.pop_front());
        rd_en = 1'b1;
      end
    end else begin
      rd_en = 1'b0;
    end
  end

  initial begin
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    in_samples = '0;
    in_chans   = '0;
    thr_wren   = 1'b0;
    thr_addr   = '0;
    thr_wdata  = '0;
    reg_wren   = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    for (int a = 0; a < spike_pkg::CHANNELS; a++) begin
      shadow[a] = '0;
    end
    repeat (RESET_CYCLES) @(posedge bus_clk);
    #DRIVE_DLY;
    arst_n = 1'b1;

    // State straight out of reset
    read_reg_check(spike_pkg::REG_STATUS, status_value(0, 1'b0));
    read_reg_check(spike_pkg::REG_CTRL, 16'h0000);
    if (!fifo_empty) begin
      $display("FIFO is not empty after reset");
      abort_run();
    end
    for (int a = 0; a < spike_pkg::CHANNELS; a++) begin
      read_thr_check(spike_pkg::thr_addr_t'(a));
    end

    // Bank readback
    for (int a = 0; a < spike_pkg::CHANNELS; a++) begin
      write_thr(spike_pkg::thr_addr_t'(a), take_bits(32));
    end
    for (int a = 0; a < spike_pkg::CHANNELS; a++) begin
      read_thr_check(spike_pkg::thr_addr_t'(a));
    end

    // Detect off, continuous drain
    @(negedge bus_clk);
    draining = 1'b1;
    repeat (RANDOM_BUNDLES) send_random_bundle(1'b0);
    wait_drained();

    // Detect on with the random bank
    write_reg(spike_pkg::REG_CTRL, 16'h0001);
    read_reg_check(spike_pkg::REG_CTRL, 16'h0001);
    spikes_seen = 0;
    quiet_seen  = 0;
    repeat (RANDOM_BUNDLES) send_random_bundle(1'b1);
    wait_drained();
    if (spikes_seen == 0 || quiet_seen == 0) begin
      $display("Threshold traffic did not mix flagged and unflagged lanes");
      abort_run();
    end

    edge_case_test();
    wait_drained();

    // Fill past the depth with the host not reading
    @(negedge bus_clk);
    draining = 1'b0;
    repeat (OVERFLOW_BUNDLES) send_random_bundle(1'b1);
    repeat (4) @(posedge bus_clk);
    while (exp_q.size() > spike_pkg::FIFO_DEPTH) begin
      void'(exp_q.pop_back());
    end
    read_reg_check(spike_pkg::REG_STATUS, status_value(spike_pkg::FIFO_DEPTH, 1'b1));

    // Clear the sticky flag, then drain the kept words
    write_reg(spike_pkg::REG_STATUS, 16'h0001);
    read_reg_check(spike_pkg::REG_STATUS, status_value(spike_pkg::FIFO_DEPTH, 1'b0));
    @(negedge bus_clk);
    draining = 1'b1;
    wait_drained();
    read_reg_check(spike_pkg::REG_STATUS, status_value(0, 1'b0));

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
spike_pkg.sv
ctrl_regs.sv
thresh_bank.sv
spike_detect.sv
lane_serializer.sv
host_fifo.sv
spike_pipeline_top.sv
tb_spike_pipeline.sv

/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= tb_spike_pipeline
RTL_TOP   ?= spike_pipeline_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run passed"; \
	else \
		echo "Run did not pass, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
